// ==== source/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    localparam int WORD_W     = 32;
    localparam int PC_W       = 30;
    localparam int REG_IDX_W  = 4;
    localparam int CSR_ADDR_W = 12;
    localparam int ALU_OP_W   = 5;

    // Forwarding history entries
    localparam int BYPASS_DEPTH = 4;

    typedef logic [WORD_W-1:0]     word_t;
    // Word address, byte offset dropped
    typedef logic [PC_W-1:0]       pc_t;
    typedef logic [REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU
    } alu_op_e;

    // Machine mode CSRs handled by the stage
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;

endpackage

`default_nettype wire

// ==== source/exec_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_alu (
    input  wire exec_pkg::alu_op_e alu_op,
    input  wire exec_pkg::word_t   a,
    input  wire exec_pkg::word_t   b,
    input  wire exec_pkg::word_t   cmp_a,
    input  wire exec_pkg::word_t   cmp_b,
    output exec_pkg::word_t        result,
    output logic                   cond
);

    logic [4:0] shamt;
    logic       op_lt_s;
    logic       op_lt_u;
    logic       cmp_eq;
    logic       cmp_lt_s;
    logic       cmp_lt_u;

    assign shamt = b[4:0];

    // slt and sltu work on the muxed operands
    assign op_lt_s = $signed(a) < $signed(b);
    assign op_lt_u = a < b;

    // Branch compares always see the register values
    assign cmp_eq   = cmp_a == cmp_b;
    assign cmp_lt_s = $signed(cmp_a) < $signed(cmp_b);
    assign cmp_lt_u = cmp_a < cmp_b;

    always_comb begin
        case (alu_op)
            exec_pkg::ALU_SUB:  result = a - b;
            exec_pkg::ALU_AND:  result = a & b;
            exec_pkg::ALU_OR:   result = a | b;
            exec_pkg::ALU_XOR:  result = a ^ b;
            exec_pkg::ALU_SLL:  result = a << shamt;
            exec_pkg::ALU_SRL:  result = a >> shamt;
            exec_pkg::ALU_SRA:  result = exec_pkg::word_t'($signed(a) >>> shamt);
            exec_pkg::ALU_SLT:  result = exec_pkg::word_t'(op_lt_s);
            exec_pkg::ALU_SLTU: result = exec_pkg::word_t'(op_lt_u);
            exec_pkg::ALU_LUI:  result = b;
            // add, and the branch target for the compare ops
            default:            result = a + b;
        endcase
    end

    always_comb begin
        case (alu_op)
            exec_pkg::ALU_BEQ:  cond = cmp_eq;
            exec_pkg::ALU_BNE:  cond = ~cmp_eq;
            exec_pkg::ALU_BLT:  cond = cmp_lt_s;
            exec_pkg::ALU_BGE:  cond = ~cmp_lt_s;
            exec_pkg::ALU_BLTU: cond = cmp_lt_u;
            exec_pkg::ALU_BGEU: cond = ~cmp_lt_u;
            default:            cond = 1'b0;
        endcase
    end

    // Decoder must never hand over an undefined operation
    always_comb begin
        assert (!$isunknown(alu_op))
            else $error("exec_alu: alu_op is unknown");
    end

endmodule

`default_nettype wire

// ==== source/operand_bypass.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_bypass (
    input  wire                     clk,
    input  wire                     rst,
    input  wire exec_pkg::reg_idx_t rs1,
    input  wire exec_pkg::reg_idx_t rs2,
    input  wire exec_pkg::word_t    rs1_data,
    input  wire exec_pkg::word_t    rs2_data,
    input  wire                     push,
    input  wire exec_pkg::reg_idx_t push_rd,
    input  wire exec_pkg::word_t    push_data,
    input  wire                     push_is_load,
    input  wire                     load_done,
    input  wire exec_pkg::word_t    load_data,
    output exec_pkg::word_t         src1,
    output exec_pkg::word_t         src2,
    output logic                    wait_load
);

    // Entry 0 is the newest
    exec_pkg::reg_idx_t                  hist_rd      [exec_pkg::BYPASS_DEPTH];
    exec_pkg::word_t                     hist_data    [exec_pkg::BYPASS_DEPTH];
    logic [exec_pkg::BYPASS_DEPTH-1:0]   hist_valid;
    logic [exec_pkg::BYPASS_DEPTH-1:0]   hist_pending;

    // History with a returning load already written in
    exec_pkg::word_t                     fill_data    [exec_pkg::BYPASS_DEPTH];
    logic [exec_pkg::BYPASS_DEPTH-1:0]   fill_pending;

    logic                                src1_wait;
    logic                                src2_wait;

    // Returns {pending, data} of the newest match, or the file value
    function automatic logic [exec_pkg::WORD_W:0] lookup(
        input exec_pkg::reg_idx_t rs,
        input exec_pkg::word_t    rs_data
    );
        logic [exec_pkg::WORD_W:0] sel;
        sel = {1'b0, rs_data};
        for (int i = exec_pkg::BYPASS_DEPTH - 1; i >= 0; i--) begin
            if (hist_valid[i] && (hist_rd[i] == rs) && (rs != '0)) begin
                sel = {hist_pending[i], hist_data[i]};
            end
        end
        return sel;
    endfunction

    always_comb begin
        {src1_wait, src1} = lookup(rs1, rs1_data);
        {src2_wait, src2} = lookup(rs2, rs2_data);
    end

    assign wait_load = src1_wait | src2_wait;

    always_comb begin
        for (int i = 0; i < exec_pkg::BYPASS_DEPTH; i++) begin
            fill_data[i] = (load_done && hist_pending[i]) ? load_data : hist_data[i];
        end
        fill_pending = load_done ? '0 : hist_pending;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_valid   <= '0;
            hist_pending <= '0;
        end else if (push) begin
            hist_valid   <= {hist_valid[exec_pkg::BYPASS_DEPTH-2:0], 1'b1};
            hist_pending <= {fill_pending[exec_pkg::BYPASS_DEPTH-2:0], push_is_load};
        end else begin
            hist_pending <= fill_pending;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = exec_pkg::BYPASS_DEPTH - 1; i > 0; i--) begin
                hist_rd[i]   <= hist_rd[i-1];
                hist_data[i] <= fill_data[i-1];
            end
            hist_rd[0]   <= push_rd;
            hist_data[0] <= push_data;
        end else begin
            for (int i = 0; i < exec_pkg::BYPASS_DEPTH; i++) begin
                hist_data[i] <= fill_data[i];
            end
        end
    end

    // Memory side returns one load at a time
    assert property (@(posedge clk) disable iff (rst) $countones(hist_pending) <= 1)
        else $error("operand_bypass: more than one load pending");

endmodule

`default_nettype wire

// ==== source/csr_redirect.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_redirect (
    input  wire exec_pkg::pc_t   pc,
    input  wire exec_pkg::word_t src1,
    input  wire exec_pkg::word_t imm,
    input  wire exec_pkg::word_t csr_rdata,
    input  wire                  csrrw,
    input  wire                  csrrs,
    input  wire                  ecall,
    input  wire                  mret,
    input  wire                  is_jump,
    input  wire                  is_branch,
    input  wire                  cond,
    input  wire exec_pkg::word_t alu_result,
    output logic                 csr_we,
    output exec_pkg::csr_addr_t  csr_sel,
    output exec_pkg::word_t      csr_wdata,
    output exec_pkg::pc_t        next_pc,
    output logic                 redirect
);

    exec_pkg::csr_addr_t csr_addr;
    exec_pkg::pc_t       seq_pc;
    logic                csr_known;
    logic                taken;

    // CSR number sits in the low immediate bits
    assign csr_addr  = imm[exec_pkg::CSR_ADDR_W-1:0];
    assign csr_known = (csr_addr == exec_pkg::CSR_MSTATUS)
                     | (csr_addr == exec_pkg::CSR_MTVEC)
                     | (csr_addr == exec_pkg::CSR_MEPC);

    assign csr_we  = ecall | ((csrrw | csrrs) & csr_known);
    assign csr_sel = ecall ? exec_pkg::CSR_MEPC : csr_addr;

    always_comb begin
        if (ecall)
            csr_wdata = {pc, 2'b00};
        else if (csrrs)
            csr_wdata = src1 | csr_rdata;
        else if (csrrw)
            csr_wdata = src1;
        else
            csr_wdata = '0;
    end

    assign seq_pc = pc + exec_pkg::pc_t'(1);
    assign taken  = is_jump | (is_branch & cond);

    // ecall reads mtvec, mret reads mepc
    always_comb begin
        if (ecall || mret)
            next_pc = csr_rdata[exec_pkg::WORD_W-1:2];
        else if (taken)
            next_pc = alu_result[exec_pkg::WORD_W-1:2];
        else
            next_pc = seq_pc;
    end

    assign redirect = next_pc != seq_pc;

endmodule

`default_nettype wire

// ==== source/exec_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_stage (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      in_valid,
    input  wire                      mem_ready,
    input  wire                      wait_load,
    input  wire                      redirect,
    input  wire                      redirect_ack,
    input  wire exec_pkg::pc_t       next_pc,
    input  wire exec_pkg::reg_idx_t  rd,
    input  wire                      gpr_we,
    input  wire                      is_load,
    input  wire                      is_store,
    input  wire                      is_jump,
    input  wire exec_pkg::pc_t       pc,
    input  wire exec_pkg::word_t     alu_result,
    input  wire exec_pkg::word_t     src2,
    input  wire exec_pkg::word_t     csr_rdata,
    input  wire exec_pkg::word_t     csr_wdata,
    input  wire                      csr_we,
    input  wire                      csrrw,
    input  wire                      csrrs,
    input  wire exec_pkg::csr_addr_t csr_sel,
    output logic                     in_ready,
    output logic                     push,
    output exec_pkg::word_t          push_data,
    output logic                     out_valid,
    output exec_pkg::reg_idx_t       out_rd,
    output logic                     out_gpr_we,
    output logic                     out_is_load,
    output logic                     out_is_store,
    output exec_pkg::word_t          out_result,
    output exec_pkg::word_t          out_store_data,
    output logic                     out_csr_we,
    output exec_pkg::word_t          out_csr_wdata,
    output exec_pkg::csr_addr_t      out_csr_sel,
    output logic                     redirect_valid,
    output exec_pkg::pc_t            redirect_pc
);

    logic            accept;
    logic            live;
    exec_pkg::word_t link_addr;
    exec_pkg::word_t wb_data;

    assign in_ready = mem_ready & ~wait_load;
    assign accept   = in_valid & in_ready;

    // Anything behind an unacknowledged redirect is on the wrong path
    assign live = accept & ~redirect_valid;

    assign link_addr = {pc, 2'b00} + exec_pkg::word_t'(4);

    always_comb begin
        if (csrrw || csrrs)
            wb_data = csr_rdata;
        else if (is_jump)
            wb_data = link_addr;
        else
            wb_data = alu_result;
    end

    assign push      = live & gpr_we;
    assign push_data = wb_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= live;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_rd         <= rd;
            out_gpr_we     <= gpr_we;
            out_is_load    <= is_load;
            out_is_store   <= is_store;
            out_result     <= wb_data;
            out_store_data <= src2;
            out_csr_we     <= csr_we;
            out_csr_wdata  <= csr_wdata;
            out_csr_sel    <= csr_sel;
        end
    end

    // Held until fetch takes the new PC
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_valid <= 1'b0;
        end else if (live && redirect) begin
            redirect_valid <= 1'b1;
        end else if (redirect_ack) begin
            redirect_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (live && redirect) begin
            redirect_pc <= next_pc;
        end
    end

    // Fetch only acknowledges a redirect that is pending
    assert property (@(posedge clk) disable iff (rst) redirect_ack |-> redirect_valid)
        else $error("exec_stage: redirect_ack without a pending redirect");

endmodule

`default_nettype wire

// ==== source/exec_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      in_valid,
    input  wire exec_pkg::pc_t       pc,
    input  wire exec_pkg::reg_idx_t  rd,
    input  wire exec_pkg::reg_idx_t  rs1,
    input  wire exec_pkg::reg_idx_t  rs2,
    input  wire exec_pkg::word_t     rs1_data,
    input  wire exec_pkg::word_t     rs2_data,
    input  wire exec_pkg::word_t     imm,
    input  wire exec_pkg::alu_op_e   alu_op,
    input  wire                      src1_is_pc,
    input  wire                      src2_is_imm,
    input  wire                      is_jump,
    input  wire                      is_branch,
    input  wire                      is_load,
    input  wire                      is_store,
    input  wire                      gpr_we,
    input  wire                      csrrw,
    input  wire                      csrrs,
    input  wire                      ecall,
    input  wire                      mret,
    input  wire exec_pkg::word_t     csr_rdata,
    input  wire                      mem_ready,
    input  wire                      load_done,
    input  wire exec_pkg::word_t     load_data,
    input  wire                      redirect_ack,
    output logic                     in_ready,
    output logic                     out_valid,
    output exec_pkg::reg_idx_t       out_rd,
    output logic                     out_gpr_we,
    output logic                     out_is_load,
    output logic                     out_is_store,
    output exec_pkg::word_t          out_result,
    output exec_pkg::word_t          out_store_data,
    output logic                     out_csr_we,
    output exec_pkg::word_t          out_csr_wdata,
    output exec_pkg::csr_addr_t      out_csr_sel,
    output logic                     redirect_valid,
    output exec_pkg::pc_t            redirect_pc
);

    exec_pkg::word_t     src1;
    exec_pkg::word_t     src2;
    exec_pkg::word_t     alu_a;
    exec_pkg::word_t     alu_b;
    exec_pkg::word_t     alu_result;
    exec_pkg::word_t     csr_wdata;
    exec_pkg::word_t     push_data;
    exec_pkg::csr_addr_t csr_sel;
    exec_pkg::pc_t       next_pc;
    logic                cond;
    logic                wait_load;
    logic                csr_we;
    logic                redirect;
    logic                push;

    // ALU operand selection after forwarding
    assign alu_a = src1_is_pc  ? {pc, 2'b00} : src1;
    assign alu_b = src2_is_imm ? imm         : src2;

    exec_alu u_alu (
        .alu_op (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .cmp_a  (src1),
        .cmp_b  (src2),
        .result (alu_result),
        .cond   (cond)
    );

    operand_bypass u_bypass (
        .clk          (clk),
        .rst          (rst),
        .rs1          (rs1),
        .rs2          (rs2),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .push         (push),
        .push_rd      (rd),
        .push_data    (push_data),
        .push_is_load (is_load),
        .load_done    (load_done),
        .load_data    (load_data),
        .src1         (src1),
        .src2         (src2),
        .wait_load    (wait_load)
    );

    csr_redirect u_csr_redirect (
        .pc         (pc),
        .src1       (src1),
        .imm        (imm),
        .csr_rdata  (csr_rdata),
        .csrrw      (csrrw),
        .csrrs      (csrrs),
        .ecall      (ecall),
        .mret       (mret),
        .is_jump    (is_jump),
        .is_branch  (is_branch),
        .cond       (cond),
        .alu_result (alu_result),
        .csr_we     (csr_we),
        .csr_sel    (csr_sel),
        .csr_wdata  (csr_wdata),
        .next_pc    (next_pc),
        .redirect   (redirect)
    );

    exec_stage u_stage (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .mem_ready      (mem_ready),
        .wait_load      (wait_load),
        .redirect       (redirect),
        .redirect_ack   (redirect_ack),
        .next_pc        (next_pc),
        .rd             (rd),
        .gpr_we         (gpr_we),
        .is_load        (is_load),
        .is_store       (is_store),
        .is_jump        (is_jump),
        .pc             (pc),
        .alu_result     (alu_result),
        .src2           (src2),
        .csr_rdata      (csr_rdata),
        .csr_wdata      (csr_wdata),
        .csr_we         (csr_we),
        .csrrw          (csrrw),
        .csrrs          (csrrs),
        .csr_sel        (csr_sel),
        .in_ready       (in_ready),
        .push           (push),
        .push_data      (push_data),
        .out_valid      (out_valid),
        .out_rd         (out_rd),
        .out_gpr_we     (out_gpr_we),
        .out_is_load    (out_is_load),
        .out_is_store   (out_is_store),
        .out_result     (out_result),
        .out_store_data (out_store_data),
        .out_csr_we     (out_csr_we),
        .out_csr_wdata  (out_csr_wdata),
        .out_csr_sel    (out_csr_sel),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

// ==== test/exec_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_tb;

    localparam int NUM_INSTR  = 1500;
    // About 2.7 cycles per instruction covers gaps, back-pressure and load waits
    localparam int MAX_CYCLES = NUM_INSTR * 8 / 3;
    localparam int DEPTH      = exec_pkg::BYPASS_DEPTH;

    logic                clk = 1'b0;
    logic                rst;
    logic                in_valid;
    exec_pkg::pc_t       pc;
    exec_pkg::reg_idx_t  rd;
    exec_pkg::reg_idx_t  rs1;
    exec_pkg::reg_idx_t  rs2;
    exec_pkg::word_t     rs1_data;
    exec_pkg::word_t     rs2_data;
    exec_pkg::word_t     imm;
    exec_pkg::alu_op_e   alu_op;
    logic                src1_is_pc;
    logic                src2_is_imm;
    logic                is_jump;
    logic                is_branch;
    logic                is_load;
    logic                is_store;
    logic                gpr_we;
    logic                csrrw;
    logic                csrrs;
    logic                ecall;
    logic                mret;
    exec_pkg::word_t     csr_rdata;
    logic                mem_ready;
    logic                load_done;
    exec_pkg::word_t     load_data;
    logic                redirect_ack;
    logic                in_ready;
    logic                out_valid;
    exec_pkg::reg_idx_t  out_rd;
    logic                out_gpr_we;
    logic                out_is_load;
    logic                out_is_store;
    exec_pkg::word_t     out_result;
    exec_pkg::word_t     out_store_data;
    logic                out_csr_we;
    exec_pkg::word_t     out_csr_wdata;
    exec_pkg::csr_addr_t out_csr_sel;
    logic                redirect_valid;
    exec_pkg::pc_t       redirect_pc;

    // Reference model state, entry 0 newest
    exec_pkg::reg_idx_t  m_rd   [DEPTH];
    exec_pkg::word_t     m_data [DEPTH];
    logic [DEPTH-1:0]    m_val;
    logic [DEPTH-1:0]    m_pend;
    logic                m_out_valid;
    logic                m_rv;
    exec_pkg::pc_t       m_rpc;
    exec_pkg::reg_idx_t  e_rd;
    logic                e_gpr_we;
    logic                e_is_load;
    logic                e_is_store;
    exec_pkg::word_t     e_result;
    exec_pkg::word_t     e_store;
    logic                e_csr_we;
    exec_pkg::word_t     e_csr_wdata;
    exec_pkg::csr_addr_t e_csr_sel;
    logic                e_csr_op;

    logic                acc;
    logic [1:0]          ld_wait;
    logic [31:0]         rng_state = 32'hc5d8_ee1a;
    int                  accepted_count = 0;
    int                  cycle_count = 0;

    exec_top dut_i (.*);

    always #20 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            report_failure($sformatf("Timeout: only %0d of %0d instructions accepted in %0d cycles",
                                     accepted_count, NUM_INSTR, cycle_count));
        end
    end

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            report_failure($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic logic signed_less(input exec_pkg::word_t x, input exec_pkg::word_t y);
        return (x[31] != y[31]) ? x[31] : (x < y);
    endfunction

    function automatic exec_pkg::word_t alu_model(input exec_pkg::alu_op_e op,
                                                  input exec_pkg::word_t a,
                                                  input exec_pkg::word_t b);
        logic [63:0] ext;
        ext = {{32{a[31]}}, a} >> b[4:0];
        case (op)
            exec_pkg::ALU_SUB:  return a + ~b + 32'd1;
            exec_pkg::ALU_AND:  return a & b;
            exec_pkg::ALU_OR:   return a | b;
            exec_pkg::ALU_XOR:  return a ^ b;
            exec_pkg::ALU_SLL:  return a << b[4:0];
            exec_pkg::ALU_SRL:  return a >> b[4:0];
            exec_pkg::ALU_SRA:  return ext[31:0];
            exec_pkg::ALU_SLT:  return {31'd0, signed_less(a, b)};
            exec_pkg::ALU_SLTU: return {31'd0, a < b};
            exec_pkg::ALU_LUI:  return b;
            // Branch ops produce the target address
            default:            return a + b;
        endcase
    endfunction

    function automatic logic branch_taken(input exec_pkg::alu_op_e op,
                                          input exec_pkg::word_t x, input exec_pkg::word_t y);
        case (op)
            exec_pkg::ALU_BEQ:  return x == y;
            exec_pkg::ALU_BNE:  return x != y;
            exec_pkg::ALU_BLT:  return signed_less(x, y);
            exec_pkg::ALU_BGE:  return !signed_less(x, y);
            exec_pkg::ALU_BLTU: return x < y;
            exec_pkg::ALU_BGEU: return x >= y;
            default:            return 1'b0;
        endcase
    endfunction

    task automatic forward_lookup(input exec_pkg::reg_idx_t rs, input exec_pkg::word_t file_val,
                                  output exec_pkg::word_t v, output logic w);
        logic found;
        v = file_val;
        w = 1'b0;
        found = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (!found && rs != 4'd0 && m_val[i] && m_rd[i] == rs) begin
                v = m_data[i];
                w = m_pend[i];
                found = 1'b1;
            end
        end
    endtask

    // Checks the outputs, then advances the model across the coming edge
    task automatic step_model();
        exec_pkg::word_t s1;
        exec_pkg::word_t s2;
        exec_pkg::word_t a;
        exec_pkg::word_t b;
        exec_pkg::word_t res;
        exec_pkg::word_t wb;
        exec_pkg::pc_t   seq;
        exec_pkg::pc_t   npc;
        logic            w1;
        logic            w2;
        logic            ready;
        logic            live;
        logic            csr_op;
        logic            known;
        expect_equal("out_valid", 32'(out_valid), 32'(m_out_valid));
        expect_equal("redirect_valid", 32'(redirect_valid), 32'(m_rv));
        if (m_out_valid) begin
            expect_equal("out_rd", 32'(out_rd), 32'(e_rd));
            expect_equal("out_gpr_we", 32'(out_gpr_we), 32'(e_gpr_we));
            expect_equal("out_is_load", 32'(out_is_load), 32'(e_is_load));
            expect_equal("out_is_store", 32'(out_is_store), 32'(e_is_store));
            expect_equal("out_result", out_result, e_result);
            expect_equal("out_store_data", out_store_data, e_store);
            expect_equal("out_csr_we", 32'(out_csr_we), 32'(e_csr_we));
            if (e_csr_op) begin
                expect_equal("out_csr_wdata", out_csr_wdata, e_csr_wdata);
                expect_equal("out_csr_sel", 32'(out_csr_sel), 32'(e_csr_sel));
            end
        end
        if (m_rv) begin
            expect_equal("redirect_pc", 32'(redirect_pc), 32'(m_rpc));
        end

        forward_lookup(rs1, rs1_data, s1, w1);
        forward_lookup(rs2, rs2_data, s2, w2);
        ready = mem_ready && !w1 && !w2;
        expect_equal("in_ready", 32'(in_ready), 32'(ready));
        acc  = in_valid && ready;
        live = acc && !m_rv;

        a   = src1_is_pc ? {pc, 2'b00} : s1;
        b   = src2_is_imm ? imm : s2;
        res = alu_model(alu_op, a, b);
        seq = pc + 30'd1;
        if (ecall || mret)
            npc = csr_rdata[31:2];
        else if (is_jump || (is_branch && branch_taken(alu_op, s1, s2)))
            npc = res[31:2];
        else
            npc = seq;
        csr_op = csrrw || csrrs;
        known  = imm[11:0] == exec_pkg::CSR_MSTATUS || imm[11:0] == exec_pkg::CSR_MTVEC
                 || imm[11:0] == exec_pkg::CSR_MEPC;
        if (csr_op)
            wb = csr_rdata;
        else if (is_jump)
            wb = {pc, 2'b00} + 32'd4;
        else
            wb = res;

        if (acc) begin
            accepted_count++;
        end
        if (ready) begin
            m_out_valid = live;
        end
        if (live) begin
            e_rd        = rd;
            e_gpr_we    = gpr_we;
            e_is_load   = is_load;
            e_is_store  = is_store;
            e_result    = wb;
            e_store     = s2;
            e_csr_we    = ecall || (csr_op && known);
            e_csr_sel   = ecall ? exec_pkg::CSR_MEPC : imm[11:0];
            e_csr_wdata = ecall ? {pc, 2'b00} : (csrrs ? (s1 | csr_rdata) : s1);
            e_csr_op    = csr_op || ecall;
        end
        if (live && npc != seq) begin
            m_rv  = 1'b1;
            m_rpc = npc;
        end else if (redirect_ack) begin
            m_rv = 1'b0;
        end

        // Returning load fills before the shift
        for (int i = 0; i < DEPTH; i++) begin
            if (load_done && m_pend[i]) begin
                m_data[i] = load_data;
                m_pend[i] = 1'b0;
            end
        end
        if (live && gpr_we) begin
            for (int i = DEPTH - 1; i > 0; i--) begin
                m_rd[i]   = m_rd[i-1];
                m_data[i] = m_data[i-1];
                m_val[i]  = m_val[i-1];
                m_pend[i] = m_pend[i-1];
            end
            m_rd[0]   = rd;
            m_data[0] = wb;
            m_val[0]  = 1'b1;
            m_pend[0] = is_load;
        end
    endtask

    task automatic new_instruction();
        logic [31:0]         r;
        logic [31:0]         k;
        exec_pkg::csr_addr_t addr;
        r = next_rand();
        k = next_rand();
        case (r[6:5])
            2'd0:    addr = exec_pkg::CSR_MSTATUS;
            2'd1:    addr = exec_pkg::CSR_MTVEC;
            2'd2:    addr = exec_pkg::CSR_MEPC;
            default: addr = k[11:0];
        endcase
        in_valid    <= (r[30:28] != 3'd0);
        pc          <= exec_pkg::pc_t'(next_rand());
        rd          <= {1'b0, r[10:8]};
        rs1         <= {1'b0, r[13:11]};
        rs2         <= {1'b0, r[16:14]};
        rs1_data    <= next_rand();
        rs2_data    <= next_rand();
        imm         <= k;
        csr_rdata   <= next_rand();
        src1_is_pc  <= r[17];
        src2_is_imm <= r[18];
        alu_op      <= exec_pkg::alu_op_e'(5'(r[26:19] % 8'd11));
        {is_jump, is_branch, is_load, is_store} <= 4'b0000;
        {csrrw, csrrs, ecall, mret} <= 4'b0000;
        gpr_we      <= 1'b1;
        case (r[3:0])
            4'd8, 4'd9: begin
                alu_op      <= exec_pkg::alu_op_e'(5'd11 + 5'(r[7:5] % 3'd6));
                is_branch   <= 1'b1;
                gpr_we      <= 1'b0;
                src1_is_pc  <= 1'b1;
                src2_is_imm <= 1'b1;
            end
            4'd10: begin
                alu_op      <= exec_pkg::ALU_ADD;
                is_jump     <= 1'b1;
                src2_is_imm <= 1'b1;
            end
            4'd11: begin
                // Only one load may be outstanding
                if (m_pend == '0) begin
                    alu_op      <= exec_pkg::ALU_ADD;
                    is_load     <= 1'b1;
                    src2_is_imm <= 1'b1;
                end
            end
            4'd12: begin
                alu_op      <= exec_pkg::ALU_ADD;
                is_store    <= 1'b1;
                gpr_we      <= 1'b0;
                src2_is_imm <= 1'b1;
            end
            4'd13: begin
                csrrw <= r[7];
                csrrs <= !r[7];
                imm   <= {k[31:12], addr};
            end
            4'd14: begin
                ecall  <= 1'b1;
                gpr_we <= 1'b0;
            end
            4'd15: begin
                mret   <= 1'b1;
                gpr_we <= 1'b0;
            end
            default: ;
        endcase
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        r = next_rand();
        mem_ready    <= (r[2:0] != 3'd0);
        redirect_ack <= m_rv && (r[4:3] == 2'd0);
        load_done    <= 1'b0;
        if (m_pend != '0) begin
            if (ld_wait == 2'd0) begin
                load_done <= 1'b1;
                load_data <= next_rand();
                ld_wait   = r[6:5];
            end else begin
                ld_wait = ld_wait - 2'd1;
            end
        end
        // A held instruction stays on the inputs until it is taken
        if (acc || !in_valid) begin
            new_instruction();
        end
    endtask

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        pc = '0;
        rd = '0;
        rs1 = '0;
        rs2 = '0;
        rs1_data = '0;
        rs2_data = '0;
        imm = '0;
        alu_op = exec_pkg::ALU_ADD;
        {src1_is_pc, src2_is_imm, is_jump, is_branch} = 4'b0000;
        {is_load, is_store, gpr_we} = 3'b000;
        {csrrw, csrrs, ecall, mret} = 4'b0000;
        csr_rdata = '0;
        mem_ready = 1'b0;
        load_done = 1'b0;
        load_data = '0;
        redirect_ack = 1'b0;
        m_val = '0;
        m_pend = '0;
        m_out_valid = 1'b0;
        m_rv = 1'b0;
        acc = 1'b0;
        ld_wait = 2'd1;

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        while (accepted_count < NUM_INSTR) begin
            @(negedge clk);
            step_model();
            @(posedge clk);
            drive_inputs();
        end
        in_valid <= 1'b0;
        @(negedge clk);
        step_model();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
source/exec_pkg.sv
source/exec_alu.sv
source/operand_bypass.sv
source/csr_redirect.sv
source/exec_stage.sv
source/exec_top.sv
test/exec_tb.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := exec_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -j 0

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
